/* aes_pkg.sv */
`default_nettype none

package aes_pkg;

	localparam int AES_ROUNDS = 10;		// aes-128 round count
	localparam logic [7:0] AES_RCON_INIT = 8'h01;	// rcon for the first expansion step

	// one 128-bit state word with two readings
	typedef union packed {
		logic [0:15][7:0] bytes;	// byte view, bytes[0] is the first input byte
		logic [0:3][31:0] cols;		// column view, cols[0] holds bytes 0..3
	} aes_state_u;

	// multiply by x in GF(2^8) modulo x^8+x^4+x^3+x+1
	function automatic logic [7:0] aes_xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);	// reduce when msb shifts out
	endfunction

	// forward s-box, one table row per high nibble
	function automatic logic [7:0] aes_sbox(input logic [7:0] b);
		logic [127:0] row;	// sixteen entries, entry 0 in the top byte
		case (b[7:4])
			4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
			4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
			4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
			4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
			4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
			4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
			4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
			4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
			4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
			4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
			4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
			4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
			4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
			4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
			4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
			default: row = 128'h8ca1890dbfe6426841992d0fb054bb16;	// row f
		endcase
		return row[8*(15 - b[3:0]) +: 8];	// low nibble picks the column
	endfunction

endpackage

`default_nettype wire

/* aes_key_schedule.sv */
`default_nettype none

module aes_key_schedule
	import aes_pkg::*;
(
	input wire			CLK,
	input wire			RST,
	input wire			load_i,		// take key_i as round key 0
	input wire			step_i,		// advance to the next round key
	input wire	[127:0]	key_i,		// main key from the start interface
	output logic	[127:0]	round_key_o	// next round key, combinational
);

	logic [127:0] key_q;	// current round key
	logic [7:0] rcon_q;	// round constant for the next expansion
	logic [3:0] step_cnt;	// steps taken since the last load
	logic [31:0] w0, w1, w2, w3;	// current key words, w0 on top
	logic [31:0] t;		// transformed last word
	logic [31:0] n0, n1, n2, n3;	// next key words

	assign {w0, w1, w2, w3} = key_q;

	// rotword, subword and rcon on the last word
	assign t = {aes_sbox(w3[23:16]), aes_sbox(w3[15:8]),
		aes_sbox(w3[7:0]), aes_sbox(w3[31:24])} ^ {rcon_q, 24'h0};

	assign n0 = w0 ^ t;	// running xor through the words
	assign n1 = w1 ^ n0;
	assign n2 = w2 ^ n1;
	assign n3 = w3 ^ n2;
	assign round_key_o = {n0, n1, n2, n3};

	always_ff @(posedge CLK)
	begin
		if (load_i)
			key_q <= key_i;
		else if (step_i)
			key_q <= round_key_o;	// keep the key just used
	end

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			rcon_q <= AES_RCON_INIT;
			step_cnt <= '0;
		end
		else if (load_i)
		begin
			rcon_q <= AES_RCON_INIT;	// restart the constant sequence
			step_cnt <= '0;
		end
		else if (step_i)
		begin
			rcon_q <= aes_xtime(rcon_q);	// 01,02,04 .. 80,1b,36
			step_cnt <= step_cnt + 4'd1;
		end
	end

	// the core must never ask for both in one cycle
	a_load_step_excl: assert property (@(posedge CLK) disable iff (!RST)
		!(load_i && step_i))
		else $error("key schedule got load and step together");

	// no step beyond the tenth round key after a load
	a_step_limit: assert property (@(posedge CLK) disable iff (!RST)
		step_i |-> (step_cnt < 4'(AES_ROUNDS)))
		else $error("key schedule stepped past round %0d", AES_ROUNDS);

endmodule

`default_nettype wire

/* aes_mix_columns.sv */
`default_nettype none

module aes_mix_columns
	import aes_pkg::*;
(
	input wire	[127:0]	state_i,	// state after shiftrows
	output logic	[127:0]	state_o		// mixed state
);

	aes_state_u in_s;
	aes_state_u out_s;

	// one column times the fixed matrix {02 03 01 01} rotated per row
	function automatic logic [31:0] mix_col(input logic [31:0] col);
		logic [7:0] a0, a1, a2, a3;	// column bytes, a0 on top
		logic [7:0] d0, d1, d2, d3;	// doubled bytes
		{a0, a1, a2, a3} = col;
		d0 = aes_xtime(a0);
		d1 = aes_xtime(a1);
		d2 = aes_xtime(a2);
		d3 = aes_xtime(a3);
		// tripling is doubling xor the byte itself
		return {d0 ^ d1 ^ a1 ^ a2 ^ a3,
			a0 ^ d1 ^ d2 ^ a2 ^ a3,
			a0 ^ a1 ^ d2 ^ d3 ^ a3,
			d0 ^ a0 ^ a1 ^ a2 ^ d3};
	endfunction

	assign in_s = state_i;

	always_comb
	begin
		for (int c = 0; c < 4; c++)
		begin
			out_s.cols[c] = mix_col(in_s.cols[c]);	// columns are independent
		end
	end

	assign state_o = out_s;

endmodule

`default_nettype wire

/* aes_round.sv */
`default_nettype none

module aes_round
	import aes_pkg::*;
(
	input wire	[127:0]	state_i,	// state entering the round
	input wire	[127:0]	round_key_i,	// key for this round
	input wire			last_round_i,	// round 10 skips mixcolumns
	output logic	[127:0]	state_o		// state leaving the round
);

	aes_state_u in_s;	// incoming state
	aes_state_u sub_s;	// after subbytes
	aes_state_u shift_s;	// after shiftrows
	logic [127:0] mix_out;	// after mixcolumns
	logic [127:0] pre_key;	// input to addroundkey

	assign in_s = state_i;

	// subbytes over all sixteen bytes
	always_comb
	begin
		for (int i = 0; i < 16; i++)
		begin
			sub_s.bytes[i] = aes_sbox(in_s.bytes[i]);
		end
	end

	// shiftrows, row r rotates left by r columns
	// byte r+4c sits in row r, column c
	always_comb
	begin
		for (int r = 0; r < 4; r++)
		begin
			for (int c = 0; c < 4; c++)
			begin
				shift_s.bytes[r + 4*c] = sub_s.bytes[r + 4*((c + r) % 4)];
			end
		end
	end

	aes_mix_columns u_mix_columns (
		.state_i	(shift_s),
		.state_o	(mix_out)
	);

	assign pre_key = last_round_i ? shift_s : mix_out;	// bypass on the final round
	assign state_o = pre_key ^ round_key_i;			// addroundkey

endmodule

`default_nettype wire

/* aes_encryption.sv */
`default_nettype none

module aes_encryption
	import aes_pkg::*;
(
	input wire			CLK,
	input wire			RST,
	input wire			start_i,	// one-cycle start strobe
	input wire	[127:0]	plaintext_i,	// sampled on an accepted start
	input wire	[127:0]	key_i,		// main key, sampled with the plaintext
	input wire	[127:0]	round_key_i,	// next round key from the schedule
	output logic			key_load_o,	// schedule takes the main key
	output logic			key_step_o,	// schedule moves to the next key
	output logic	[127:0]	ciphertext_o,	// state register, held after the block
	output logic			valid_o,	// one cycle after the last round
	output logic			busy_o		// rounds in progress
);

	logic accept;		// start seen while idle
	logic last_round;	// round 10 is being computed
	logic [3:0] round_cnt;	// round computed this cycle, 0 when idle
	aes_state_u state_q;	// running state, ciphertext at the end
	logic [127:0] round_out;	// next state from the round datapath

	// a start during a block is dropped, no queue behind it
	assign accept = start_i && !busy_o;

	assign last_round = busy_o && (round_cnt == 4'(AES_ROUNDS));

	assign key_load_o = accept;	// key 0 goes in with the plaintext
	assign key_step_o = busy_o;	// one step per round edge

	assign ciphertext_o = state_q;

	aes_round u_round (
		.state_i	(state_q),
		.round_key_i	(round_key_i),
		.last_round_i	(last_round),
		.state_o	(round_out)
	);

	// round counter and busy flag
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			busy_o <= 1'b0;
			round_cnt <= '0;
		end
		else if (accept)
		begin
			busy_o <= 1'b1;
			round_cnt <= 4'd1;	// round 1 runs in the next cycle
		end
		else if (last_round)
		begin
			busy_o <= 1'b0;	// idle again, next start can land with valid
			round_cnt <= '0;
		end
		else if (busy_o)
			round_cnt <= round_cnt + 4'd1;
	end

	// state register
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			state_q <= '0;
		else if (accept)
			state_q <= plaintext_i ^ key_i;	// initial addroundkey
		else if (busy_o)
			state_q <= round_out;		// rounds 1..10
	end

	// valid strobe follows the edge that stores round 10
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			valid_o <= 1'b0;
		else
			valid_o <= last_round;
	end

	a_cnt_range: assert property (@(posedge CLK) disable iff (!RST)
		round_cnt <= 4'(AES_ROUNDS))
		else $error("round counter at %0d", round_cnt);

	// a result needs a full run of rounds with the schedule no longer stepping
	a_valid_after_rounds: assert property (@(posedge CLK) disable iff (!RST)
		valid_o |-> !key_step_o && $past(busy_o, AES_ROUNDS))
		else $error("valid without ten busy cycles before it");

endmodule

`default_nettype wire

/* aes_encrypt_top.sv */
`default_nettype none

module aes_encrypt_top (
	input wire			CLK,
	input wire			RST,
	input wire			start_i,	// start strobe, ignored while busy
	input wire	[127:0]	key_i,		// aes-128 key
	input wire	[127:0]	plaintext_i,	// block to encrypt
	output logic	[127:0]	ciphertext_o,	// result, held until the next start
	output logic			valid_o,	// result strobe
	output logic			busy_o		// block in flight
);

	logic key_load;		// core to schedule, load main key
	logic key_step;		// core to schedule, next round key
	logic [127:0] round_key;	// schedule to core

	aes_encryption u_encryption (
		.CLK		(CLK),
		.RST		(RST),
		.start_i	(start_i),
		.plaintext_i	(plaintext_i),
		.key_i		(key_i),
		.round_key_i	(round_key),
		.key_load_o	(key_load),
		.key_step_o	(key_step),
		.ciphertext_o	(ciphertext_o),
		.valid_o	(valid_o),
		.busy_o		(busy_o)
	);

	// round keys generated on the fly, one per round
	aes_key_schedule u_key_schedule (
		.CLK		(CLK),
		.RST		(RST),
		.load_i		(key_load),
		.step_i		(key_step),
		.key_i		(key_i),
		.round_key_o	(round_key)
	);

endmodule

`default_nettype wire

/* tb_aes_encrypt.sv */
`default_nettype none

module tb_aes_encrypt;

	localparam int NUM_VEC = 7;		// vectors in the stimulus file
	localparam int LATENCY = 10;		// edges from the accepting edge to valid
	localparam int WAIT_LIMIT = 20;		// cycles before a wait for valid gives up
	localparam int INTRUDE_CYCLE = 5;	// cycle of the start issued while busy

	logic CLK;
	logic RST;
	logic start;			// start strobe to the dut
	logic [127:0] key;
	logic [127:0] plaintext;
	wire [127:0] ciphertext;
	wire valid;
	wire busy;

	logic [127:0] vec_mem [0:3*NUM_VEC-1];	// key, plaintext, ciphertext per vector
	integer seed;			// state for $random
	int gap;			// extra idle cycles between blocks

	aes_encrypt_top dut (
		.CLK		(CLK),
		.RST		(RST),
		.start_i	(start),
		.key_i		(key),
		.plaintext_i	(plaintext),
		.ciphertext_o	(ciphertext),
		.valid_o	(valid),
		.busy_o		(busy)
	);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;	// period 10

	task automatic stop_with_failure();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		$display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
		stop_with_failure();
	endtask

	// idle dut holding a given result
	task automatic check_idle(input logic [127:0] exp_ct);
		assert (valid === 1'b0) else report_mismatch("valid_o", 0, valid);
		assert (busy === 1'b0) else report_mismatch("busy_o", 0, busy);
		assert (ciphertext === exp_ct) else report_mismatch("ciphertext_o", exp_ct, ciphertext);
	endtask

	// called on a falling edge so that the next rising edge samples the start
	task automatic drive_start(input int v);
		start = 1'b1;
		key = vec_mem[3*v];
		plaintext = vec_mem[3*v + 1];
	endtask

	// count falling edges up to valid and optionally fire a start while busy
	task automatic await_result(input int v, input int intruder);
		int cycles;
		logic [127:0] exp_ct;
		cycles = 0;
		exp_ct = vec_mem[3*v + 2];
		do
		begin
			@(negedge CLK);
			cycles++;
			start = 1'b0;		// strobe lasts one cycle
			if (intruder >= 0 && cycles == INTRUDE_CYCLE)
			begin
				start = 1'b1;	// lands on a busy dut
				key = vec_mem[3*intruder];
				plaintext = vec_mem[3*intruder + 1];
			end
			if (cycles > WAIT_LIMIT)
			begin
				$display("valid_o never arrived within %0d cycles of a start", WAIT_LIMIT);
				stop_with_failure();
			end
			if (valid !== 1'b1)
				assert (busy === 1'b1) else report_mismatch("busy_o", 1, busy);
		end
		while (valid !== 1'b1);
		// the first falling edge comes before E1 so valid shows on the one after E10
		assert (cycles - 1 == LATENCY)
			else report_mismatch("valid_o latency", LATENCY, cycles - 1);
		assert (busy === 1'b0) else report_mismatch("busy_o", 0, busy);	// falls with valid
		assert (ciphertext === exp_ct) else report_mismatch("ciphertext_o", exp_ct, ciphertext);
	endtask

	// result must stay put and valid must not come back
	task automatic hold_result(input int v, input int n);
		repeat (n)
		begin
			@(negedge CLK);
			check_idle(vec_mem[3*v + 2]);
		end
	endtask

	initial
	begin
		seed = 32'ha0bf;
		RST = 1'b0;
		start = 1'b0;
		key = '0;
		plaintext = '0;
		$readmemh("aes_stimulus.hex", vec_mem);
		if ($isunknown(vec_mem[3*NUM_VEC - 1]) || vec_mem[3*NUM_VEC - 1] == '0)
		begin
			$display("stimulus file aes_stimulus.hex did not load completely");
			stop_with_failure();
		end

		// outputs stay quiet through 16 reset cycles
		repeat (16)
		begin
			@(negedge CLK);
			check_idle('0);
		end
		RST = 1'b1;
		@(negedge CLK);
		check_idle('0);		// still clear right after release

		// every vector once with a random idle gap after each result
		for (int v = 0; v < NUM_VEC; v++)
		begin
			drive_start(v);
			await_result(v, -1);
			gap = $unsigned($random(seed)) % 4;
			hold_result(v, 1 + gap);
		end

		// start in the middle of a block is dropped
		drive_start(2);
		await_result(2, 1);
		hold_result(2, 12);	// a taken second start would strobe valid here

		// next start in the same cycle as valid
		drive_start(1);
		await_result(1, -1);
		drive_start(0);
		await_result(0, -1);
		drive_start(3);		// and once more from that one
		await_result(3, -1);
		hold_result(3, 4);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* aes_stimulus.hex */
// one vector per line: key, plaintext, expected ciphertext
// each column is one 128-bit word, first byte leftmost
// fips-197 appendix b example
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
// fips-197 appendix c.1
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
// all-zero key and block
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
// ecb-aes128 blocks 1 to 4 under the appendix b key
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4

/* build.f */
aes_pkg.sv
aes_key_schedule.sv
aes_mix_columns.sv
aes_round.sv
aes_encryption.sv
aes_encrypt_top.sv
tb_aes_encrypt.sv

/* run_sim.sh */
#!/bin/sh
# build and run the aes testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module tb_aes_encrypt -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_aes_encrypt 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
